// File: tests/tap_tests.txt
# code opcode dr_len expected_tdo, all columns hex
# codes: 1 idcode after reset, 2 ir capture, 3 bypass random, 4 boundary scan, 5 tms reset
1 2 20 149511c3
1 0 20 149511c3
2 2 4 00000005
2 f 4 00000005
2 0 4 00000005
2 1 4 00000005
2 9 4 00000005
3 f 8 00000000
3 f 10 00000000
3 f 20 00000000
3 9 8 00000000
3 9 1f 00000000
3 3 c 00000000
3 4 5 00000000
3 a 18 00000000
4 0 8 000000a5
4 0 10 0000c3e1
4 1 8 0000005a
4 1 20 deadbeef
4 0 1 00000001
5 f 20 149511c3
5 0 20 149511c3
5 9 20 149511c3
5 1 20 149511c3
5 2 20 149511c3

// File: tb.f
rtl/tap_instr_pkg.sv
rtl/tap_state_pkg.sv
rtl/tap_fsm.sv
rtl/tap_instr_reg.sv
rtl/tap_data_regs.sv
rtl/tap_tdo_out.sv
rtl/tap_top.sv
tests/tap_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TAP testbench with Verilator, pass or fail taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tap_tb -o tap_sim
./obj_dir/tap_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log
then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: tests/tap_tb.sv
// Testbench for the JTAG TAP: clock, reset, scan tasks, test-file reader and typed compare tasks
module tap_tb
  import tap_instr_pkg::*;
  import tap_state_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned WAIT_LIMIT   = 64;   // Cycles allowed for any wait loop

  logic tck;
  logic trst;
  logic tms;
  logic tdi;
  logic bs_tdi;
  logic tdo;
  logic tdo_oe;
  logic tdo_chain;
  logic shift_dr;
  logic pause_dr;
  logic update_dr;
  logic capture_dr;
  logic extest_sel;
  logic sample_sel;
  logic [3:0] seen;                            // capture, shift, pause, update
  int         errors;
  int         checks;

  tap_top u_tap_top (
    .tck_pad_i               (tck),
    .trst_pad_i              (trst),
    .tms_pad_i               (tms),
    .tdi_pad_i               (tdi),
    .bs_chain_tdi_i          (bs_tdi),
    .tdo_pad_o               (tdo),
    .tdo_padoe_o             (tdo_oe),
    .tdo_o                   (tdo_chain),
    .shift_dr_o              (shift_dr),
    .pause_dr_o              (pause_dr),
    .update_dr_o             (update_dr),
    .capture_dr_o            (capture_dr),
    .extest_select_o         (extest_sel),
    .sample_preload_select_o (sample_sel)
  );

  initial tck = 1'b0;
  always #50 tck = ~tck;                       // 100 ns period

  // DR strobes seen since the last clear, sampled mid-cycle
  always @(negedge tck)
    seen = seen | {capture_dr, shift_dr, pause_dr, update_dr};

  task automatic check_word(input string name, input logic [IDCODE_LEN-1:0] got,
                            input logic [IDCODE_LEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_instr(input string name, input tap_instr_e got, input tap_instr_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input instr_sel_t got, input instr_sel_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  // One-hot select from the opcode table, unknown codes pick bypass
  function automatic instr_sel_t expected_sel(input logic [IR_LEN-1:0] op);
    instr_sel_t s;
    s = '0;
    case (op)
      4'b0000: s.extest         = 1'b1;
      4'b0001: s.sample_preload = 1'b1;
      4'b0010: s.idcode         = 1'b1;
      default: s.bypass         = 1'b1;
    endcase
    return s;
  endfunction

  function automatic logic [IDCODE_LEN-1:0] mask_of(input int n);
    logic [63:0] m;
    m = (64'd1 << n) - 64'd1;
    return m[IDCODE_LEN-1:0];
  endfunction

  // One TCK: sample TDO on the edge, then drive the next pins
  task automatic step(input logic t, input logic d, input logic b, output logic o);
    @(posedge tck);
    o = tdo;
    check_word("tdo_o", {31'd0, tdo_chain}, {31'd0, tdi});   // Chain sees TDI directly
    tms    <= t;
    tdi    <= d;
    bs_tdi <= b;
  endtask

  // Shift n bits LSB first, last bit leaves with TMS high
  task automatic shift_bits(input int n, input logic [IDCODE_LEN-1:0] din,
                            input logic [IDCODE_LEN-1:0] bsin,
                            output logic [IDCODE_LEN-1:0] dout);
    logic o;
    dout = '0;
    for (int i = 0; i < n; i++)
    begin
      step(i == n - 1, din[i], bsin[i], o);
      if (i > 0)
      begin
        dout[i-1] = o;
        check_word("tdo_padoe_o", {31'd0, tdo_oe}, 32'd1);
      end
    end
  endtask

  task automatic ir_scan(input logic [IR_LEN-1:0] din, output logic [IR_LEN-1:0] dout);
    logic                  o;
    logic [IDCODE_LEN-1:0] w;
    step(1'b1, 1'b0, 1'b0, o);                 // Select-DR
    step(1'b1, 1'b0, 1'b0, o);                 // Select-IR
    step(1'b0, 1'b0, 1'b0, o);                 // Capture-IR
    step(1'b0, 1'b0, 1'b0, o);                 // Shift-IR
    shift_bits(IR_LEN, {28'd0, din}, '0, w);
    step(1'b1, 1'b0, 1'b0, o);                 // Exit1 to Update
    w[IR_LEN-1] = o;
    step(1'b0, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);                 // Latched instruction visible now
    dout = w[IR_LEN-1:0];
  endtask

  task automatic dr_scan(input int n, input logic [IDCODE_LEN-1:0] din,
                         input logic [IDCODE_LEN-1:0] bsin, input logic pause,
                         output logic [IDCODE_LEN-1:0] dout);
    logic o;
    step(1'b1, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);
    shift_bits(n, din, bsin, dout);
    if (pause)
    begin
      step(1'b0, 1'b0, 1'b0, o);               // Exit1 to Pause
      dout[n-1] = o;
      step(1'b1, 1'b0, 1'b0, o);
      step(1'b1, 1'b0, 1'b0, o);               // Exit2 to Update
    end
    else
    begin
      step(1'b1, 1'b0, 1'b0, o);
      dout[n-1] = o;
    end
    step(1'b0, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);
  endtask

  task automatic apply_reset();
    logic o;
    @(posedge tck);
    trst <= 1'b1;
    tms  <= 1'b0;
    repeat (RESET_CYCLES) @(posedge tck);
    trst <= 1'b0;
    step(1'b0, 1'b0, 1'b0, o);
    step(1'b0, 1'b0, 1'b0, o);                 // Settled in Run-Test-Idle
    seen = '0;
  endtask

  task automatic wait_padoe_low();
    int n;
    n = 0;
    while (tdo_oe !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(negedge tck);
      n++;
    end
    if (tdo_oe !== 1'b0)
    begin
      errors++;
      $display("Timed out waiting for the TDO output enable to drop");
    end
  endtask

  task automatic run_scenario(input int code, input logic [IR_LEN-1:0] op, input int len,
                              input logic [IDCODE_LEN-1:0] exp);
    logic [IDCODE_LEN-1:0] dout;
    logic [IDCODE_LEN-1:0] din;
    logic [IR_LEN-1:0]     ir_out;
    logic                  o;
    apply_reset();
    case (code)
      1:
      begin
        check_word("dr_strobes", {28'd0, capture_dr, shift_dr, pause_dr, update_dr}, '0);
        check_word("bs_selects", {30'd0, extest_sel, sample_sel}, '0);
        check_word("tdo_padoe_o", {31'd0, tdo_oe}, '0);
        check_sel("sel", u_tap_top.sel, expected_sel(INSTR_IDCODE));
        dr_scan(len, '0, '0, 1'b0, dout);
        check_word("idcode", dout, exp);
      end
      2:
      begin
        check_word("tdo_padoe_o", {31'd0, tdo_oe}, '0);
        ir_scan(op, ir_out);
        check_word("ir_capture", {28'd0, ir_out}, exp);
        check_instr("instr", u_tap_top.u_ir.instr_q, tap_instr_e'(op));
        check_sel("sel", u_tap_top.sel, expected_sel(op));
      end
      3:
      begin
        ir_scan(op, ir_out);
        check_sel("sel", u_tap_top.sel, expected_sel(op));
        din = $urandom() & mask_of(len);
        dr_scan(len, din, '0, 1'b0, dout);
        check_word("bypass", dout, (din << 1) & mask_of(len));   // Leading zero from capture
      end
      4:
      begin
        ir_scan(op, ir_out);
        check_word("bs_selects", {30'd0, extest_sel, sample_sel},
                   {30'd0, op == 4'b0000, op == 4'b0001});
        seen = '0;
        dr_scan(len, ~exp, exp, 1'b1, dout);
        check_word("bs_chain", dout, exp & mask_of(len));
        check_word("dr_strobes_seen", {28'd0, seen}, 32'hf);
      end
      5:
      begin
        ir_scan(op, ir_out);
        step(1'b1, 1'b0, 1'b0, o);
        step(1'b0, 1'b0, 1'b0, o);
        step(1'b0, 1'b0, 1'b0, o);             // Shift-DR
        repeat (3) step(1'b0, 1'b1, 1'b0, o);
        repeat (TMS_RESET_RUN) step(1'b1, 1'b0, 1'b0, o);
        step(1'b0, 1'b0, 1'b0, o);
        wait_padoe_low();
        step(1'b0, 1'b0, 1'b0, o);
        step(1'b0, 1'b0, 1'b0, o);
        check_instr("instr", u_tap_top.u_ir.instr_q, INSTR_IDCODE);
        check_sel("sel", u_tap_top.sel, expected_sel(INSTR_IDCODE));
        check_word("tdo_padoe_o", {31'd0, tdo_oe}, '0);
        dr_scan(len, '0, '0, 1'b0, dout);
        check_word("idcode", dout, exp);
      end
      default:
      begin
        errors++;
        $display("Unknown scenario code %0d in the test file", code);
      end
    endcase
  endtask

  initial
  begin
    int    fd;
    int    code;
    int    len;
    int    cnt;
    logic [IR_LEN-1:0]     op;
    logic [IDCODE_LEN-1:0] exp;
    string line;
    errors = 0;
    checks = 0;
    seen   = '0;
    trst   = 1'b1;
    tms    = 1'b0;
    tdi    = 1'b0;
    bs_tdi = 1'b0;
    cnt    = $urandom(32'h8c6e);               // Seed for bypass data
    fd = $fopen("tests/tap_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the test file");
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() < 2 || line[0] == "#")
          continue;
        cnt = $sscanf(line, "%h %h %h %h", code, op, len, exp);
        if (cnt != 4)
        begin
          errors++;
          $display("Malformed line in the test file: %s", line);
          continue;
        end
        run_scenario(code, op, len, exp);
      end
      $fclose(fd);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Overall run limit
  initial
  begin
    #5ms;
    $display("Simulation ran out of time");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: rtl/tap_top.sv
// JTAG TAP top level with controller, instruction and data registers and TDO stage
module tap_top
  import tap_instr_pkg::*;
  import tap_state_pkg::*;
(
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  input  logic tdi_pad_i,
  input  logic bs_chain_tdi_i,          // Return from boundary-scan chain
  output logic tdo_pad_o,
  output logic tdo_padoe_o,
  output logic tdo_o,                   // TDI passed on to the chain
  output logic shift_dr_o,
  output logic pause_dr_o,
  output logic update_dr_o,
  output logic capture_dr_o,
  output logic extest_select_o,
  output logic sample_preload_select_o
);

  tap_strobes_t strobes;
  instr_sel_t   sel;
  logic         ir_tdo;
  logic         idcode_tdo;
  logic         bypass_tdo;

  tap_fsm u_fsm (
    .tck_pad_i  (tck_pad_i),
    .trst_pad_i (trst_pad_i),
    .tms_pad_i  (tms_pad_i),
    .strobes_o  (strobes)
  );

  tap_instr_reg u_ir (
    .tck_pad_i  (tck_pad_i),
    .trst_pad_i (trst_pad_i),
    .tdi_pad_i  (tdi_pad_i),
    .strobes_i  (strobes),
    .ir_tdo_o   (ir_tdo),
    .sel_o      (sel)
  );

  tap_data_regs u_dr (
    .tck_pad_i    (tck_pad_i),
    .trst_pad_i   (trst_pad_i),
    .tdi_pad_i    (tdi_pad_i),
    .strobes_i    (strobes),
    .sel_i        (sel),
    .idcode_tdo_o (idcode_tdo),
    .bypass_tdo_o (bypass_tdo)
  );

  tap_tdo_out u_tdo (
    .tck_pad_i      (tck_pad_i),
    .trst_pad_i     (trst_pad_i),
    .strobes_i      (strobes),
    .sel_i          (sel),
    .ir_tdo_i       (ir_tdo),
    .idcode_tdo_i   (idcode_tdo),
    .bypass_tdo_i   (bypass_tdo),
    .bs_chain_tdi_i (bs_chain_tdi_i),
    .tdo_pad_o      (tdo_pad_o),
    .tdo_padoe_o    (tdo_padoe_o)
  );

  assign tdo_o                   = tdi_pad_i;
  assign shift_dr_o              = strobes.shift_dr;   // DR strobes for the chain
  assign pause_dr_o              = strobes.pause_dr;
  assign update_dr_o             = strobes.update_dr;
  assign capture_dr_o            = strobes.capture_dr;
  assign extest_select_o         = sel.extest;
  assign sample_preload_select_o = sel.sample_preload;

endmodule

// File: rtl/tap_tdo_out.sv
// Falling-edge retiming, TDO multiplexer and TDO pad output enable
module tap_tdo_out
  import tap_instr_pkg::*;
  import tap_state_pkg::*;
(
  input  logic         tck_pad_i,
  input  logic         trst_pad_i,
  input  tap_strobes_t strobes_i,
  input  instr_sel_t   sel_i,
  input  logic         ir_tdo_i,
  input  logic         idcode_tdo_i,
  input  logic         bypass_tdo_i,
  input  logic         bs_chain_tdi_i,
  output logic         tdo_pad_o,
  output logic         tdo_padoe_o
);

  instr_sel_t sel_neg;
  logic       shift_ir_neg;
  logic       ir_tdo_neg;
  logic       idcode_tdo_neg;
  logic       bypass_tdo_neg;
  logic       bs_tdi_neg;

  // Control side cleared by reset
  always_ff @(negedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
    begin
      sel_neg      <= SEL_RESET;
      shift_ir_neg <= 1'b0;
      tdo_padoe_o  <= 1'b0;
    end
    else
    begin
      sel_neg      <= sel_i;
      shift_ir_neg <= strobes_i.shift_ir;
      tdo_padoe_o  <= strobes_i.shift_ir | strobes_i.shift_dr;  // Drive only while shifting
    end
  end

  // Serial data bits half a cycle late
  always_ff @(negedge tck_pad_i)
  begin
    ir_tdo_neg     <= ir_tdo_i;
    idcode_tdo_neg <= idcode_tdo_i;
    bypass_tdo_neg <= bypass_tdo_i;
    bs_tdi_neg     <= bs_chain_tdi_i;
  end

  always_comb
  begin
    if (shift_ir_neg)
      tdo_pad_o = ir_tdo_neg;
    else if (sel_neg.extest | sel_neg.sample_preload)
      tdo_pad_o = bs_tdi_neg;   // Boundary-scan chain return
    else if (sel_neg.idcode)
      tdo_pad_o = idcode_tdo_neg;
    else
      tdo_pad_o = bypass_tdo_neg;
  end

endmodule

// File: rtl/tap_data_regs.sv
// IDCODE and BYPASS test data registers
module tap_data_regs
  import tap_instr_pkg::*;
  import tap_state_pkg::*;
(
  input  logic         tck_pad_i,
  input  logic         trst_pad_i,
  input  logic         tdi_pad_i,
  input  tap_strobes_t strobes_i,
  input  instr_sel_t   sel_i,
  output logic         idcode_tdo_o,
  output logic         bypass_tdo_o
);

  logic [IDCODE_LEN-1:0] idcode_q;
  logic                  bypass_q;
  logic                  idcode_shift;

  assign idcode_shift = sel_i.idcode & strobes_i.shift_dr;

  // Reloads the ID word whenever it is not shifting
  always_ff @(posedge tck_pad_i)
  begin
    if (idcode_shift)
      idcode_q <= {tdi_pad_i, idcode_q[IDCODE_LEN-1:1]};
    else
      idcode_q <= IDCODE_VALUE;
  end

  // One-bit bypass path
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      bypass_q <= 1'b0;
    else if (strobes_i.capture_dr)
      bypass_q <= 1'b0;       // Standard capture value
    else if (strobes_i.shift_dr)
      bypass_q <= tdi_pad_i;
  end

  assign idcode_tdo_o = idcode_q[0];  // LSB goes out first
  assign bypass_tdo_o = bypass_q;

endmodule

// File: rtl/tap_instr_reg.sv
// Instruction shift register, latched instruction and opcode decoder
module tap_instr_reg
  import tap_instr_pkg::*;
  import tap_state_pkg::*;
(
  input  logic         tck_pad_i,
  input  logic         trst_pad_i,
  input  logic         tdi_pad_i,
  input  tap_strobes_t strobes_i,
  output logic         ir_tdo_o,
  output instr_sel_t   sel_o
);

  logic [IR_LEN-1:0] ir_shift_q;  // Scan side of the IR
  tap_instr_e        instr_q;     // Active instruction

  // Capture fixed pattern then shift LSB first
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      ir_shift_q <= '0;
    else if (strobes_i.capture_ir)
      ir_shift_q <= IR_CAPTURE;
    else if (strobes_i.shift_ir)
      ir_shift_q <= {tdi_pad_i, ir_shift_q[IR_LEN-1:1]};  // TDI into MSB
  end

  assign ir_tdo_o = ir_shift_q[0];

  // Latch on the edge leaving Update-IR
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      instr_q <= INSTR_IDCODE;
    else if (strobes_i.test_logic_reset)
      instr_q <= INSTR_IDCODE;  // IDCODE is the default after TLR
    else if (strobes_i.update_ir)
      instr_q <= tap_instr_e'(ir_shift_q);
  end

  // Unknown opcodes fall back to bypass
  always_comb
  begin
    sel_o = '0;
    case (instr_q)
      INSTR_EXTEST:         sel_o.extest         = 1'b1;
      INSTR_SAMPLE_PRELOAD: sel_o.sample_preload = 1'b1;
      INSTR_IDCODE:         sel_o.idcode         = 1'b1;
      default:              sel_o.bypass         = 1'b1;
    endcase
  end

  a_sel_onehot : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    $onehot(sel_o));

endmodule

// File: rtl/tap_fsm.sv
// TAP controller state machine with five-TMS reset filter and state strobes
module tap_fsm
  import tap_state_pkg::*;
(
  input  logic         tck_pad_i,
  input  logic         trst_pad_i,
  input  logic         tms_pad_i,
  output tap_strobes_t strobes_o
);

  tap_state_e                   state_q;
  tap_state_e                   state_d;
  logic [TMS_RESET_RUN-2:0]     tms_hist_q;  // Previous TMS values with the newest in bit 0
  logic                         tms_reset;

  // History plus current TMS all ones
  assign tms_reset = (&tms_hist_q) & tms_pad_i;

  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      tms_hist_q <= '0;
    else
      tms_hist_q <= {tms_hist_q[TMS_RESET_RUN-3:0], tms_pad_i};
  end

  // Standard 1149.1 transition table
  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      TEST_LOGIC_RESET: state_d = tms_pad_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_pad_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = tms_pad_i ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_pad_i ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         state_d = tms_pad_i ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         state_d = tms_pad_i ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         state_d = tms_pad_i ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         state_d = tms_pad_i ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        state_d = tms_pad_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = tms_pad_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_pad_i ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         state_d = tms_pad_i ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         state_d = tms_pad_i ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         state_d = tms_pad_i ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         state_d = tms_pad_i ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        state_d = tms_pad_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
    endcase
    if (tms_reset)
      state_d = TEST_LOGIC_RESET;  // Recover from a corrupted state
  end

  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      state_q <= TEST_LOGIC_RESET;
    else
      state_q <= state_d;
  end

  // Strobes straight from the state register
  always_comb
  begin
    strobes_o.test_logic_reset = (state_q == TEST_LOGIC_RESET);
    strobes_o.capture_dr       = (state_q == CAPTURE_DR);
    strobes_o.shift_dr         = (state_q == SHIFT_DR);
    strobes_o.pause_dr         = (state_q == PAUSE_DR);
    strobes_o.update_dr        = (state_q == UPDATE_DR);
    strobes_o.capture_ir       = (state_q == CAPTURE_IR);
    strobes_o.shift_ir         = (state_q == SHIFT_IR);
    strobes_o.update_ir        = (state_q == UPDATE_IR);
  end

  // Never two scan actions at once so the IR and DR paths never fight
  a_scan_strobes_onehot0 : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    $onehot0({strobes_o.capture_dr, strobes_o.shift_dr, strobes_o.update_dr,
              strobes_o.capture_ir, strobes_o.shift_ir, strobes_o.update_ir}));

  // Five TMS ones on the pin always land in reset
  a_tms_reset : assert property (@(posedge tck_pad_i) disable iff (trst_pad_i)
    (tms_pad_i && $past(tms_pad_i, 1) && $past(tms_pad_i, 2) && $past(tms_pad_i, 3)
      && $past(tms_pad_i, 4)) |=> (state_q == TEST_LOGIC_RESET));

endmodule

// File: rtl/tap_state_pkg.sv
// TAP controller state encoding, reset run length and per-state strobe bundle
package tap_state_pkg;

  // The sixteen controller states
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  localparam int unsigned TMS_RESET_RUN = 5;  // TMS ones that force a reset

  // One flag per state of interest, high while in that state
  typedef struct packed {
    logic test_logic_reset;
    logic capture_dr;
    logic shift_dr;
    logic pause_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
  } tap_strobes_t;

endpackage

// File: rtl/tap_instr_pkg.sv
// Instruction opcodes, register widths, IDCODE value and decoded instruction selects
package tap_instr_pkg;

  localparam int unsigned IR_LEN     = 4;   // Instruction register width
  localparam int unsigned IDCODE_LEN = 32;  // Identification register width

  // Version 1, part number, manufacturer code, bit 0 fixed to one
  localparam logic [IDCODE_LEN-1:0] IDCODE_VALUE = 32'h149511c3;

  // Fixed pattern captured in Capture-IR, easy to spot on a stuck chain
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 4'b0101;

  // Supported opcodes
  typedef enum logic [IR_LEN-1:0] {
    INSTR_EXTEST         = 4'b0000,
    INSTR_SAMPLE_PRELOAD = 4'b0001,
    INSTR_IDCODE         = 4'b0010,
    INSTR_BYPASS         = 4'b1111
  } tap_instr_e;

  // Decoded selects, exactly one is high
  typedef struct packed {
    logic extest;
    logic sample_preload;
    logic idcode;
    logic bypass;
  } instr_sel_t;

  // Selects seen right after reset
  localparam instr_sel_t SEL_RESET = '{
    extest:         1'b0,
    sample_preload: 1'b0,
    idcode:         1'b1,
    bypass:         1'b0
  };

endpackage
